// ==== verilog/stream_pkg.sv ====
package stream_pkg;

	// one 64-bit data word of the packet stream
	typedef logic [63:0] word_t;

	// control byte, non-zero on the first and last word of a packet
	typedef logic [7:0] ctrl_t;

	// control and data travel together on both external streams
	typedef struct packed {
		ctrl_t ctrl;
		word_t data;
	} flit_t;

	// input FIFO holds 1 << FIFO_DEPTH_BITS entries
	localparam int FIFO_DEPTH_BITS = 2;

endpackage

// ==== verilog/ids_pkg.sv ====
package ids_pkg;

	// packet framing states of the header parser
	typedef enum logic [1:0] {
		START,
		HEADER,
		PAYLOAD
	} parse_state_t;

	localparam int NUM_SLOTS = 4;
	typedef logic [1:0] slot_t;

	// words per slot, also the longest legal packet
	localparam int SLOT_DEPTH = 32;
	typedef logic [4:0] slot_addr_t;

	localparam int SRC_WORD = 4; // body word carrying the source address
	localparam int HDR_WORDS = 5; // body words before payload

	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] count_t; // wraps

	// parser to buffer
	typedef struct packed {
		stream_pkg::flit_t flit;
		logic first;
		logic last;
		logic drop; // valid with last
	} buf_wr_t;

	// buffer to scheduler
	typedef struct packed {
		stream_pkg::flit_t flit;
		logic last;
		logic drop;
	} buf_rd_t;

endpackage

// ==== verilog/in_fifo.sv ====
module in_fifo (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input stream_pkg::flit_t in_flit,
	output logic in_ready,
	output logic fifo_valid,
	output stream_pkg::flit_t fifo_flit,
	input logic fifo_pop
);

	stream_pkg::flit_t mem [1 << stream_pkg::FIFO_DEPTH_BITS];

	logic [stream_pkg::FIFO_DEPTH_BITS-1:0] wr_ptr;
	logic [stream_pkg::FIFO_DEPTH_BITS-1:0] rd_ptr;
	logic [stream_pkg::FIFO_DEPTH_BITS:0] count;
	logic [stream_pkg::FIFO_DEPTH_BITS:0] count_n;
	logic push;
	logic pop;
	logic nearly_full_n;

	assign push = in_valid && in_ready;
	assign pop = fifo_pop && fifo_valid;

	// fall-through head
	assign fifo_valid = (count != '0);
	assign fifo_flit = mem[rd_ptr];

	always_comb begin
		count_n = count;
		if (push && !pop)
			count_n = count + 1'b1;
		else if (pop && !push)
			count_n = count - 1'b1;
	end

	// back-pressure while one entry is still free
	assign nearly_full_n = (count_n >= (1 << stream_pkg::FIFO_DEPTH_BITS) - 1);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_flit;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_ready <= 1'b0; // held low through reset
		end else begin
			count <= count_n;
			in_ready <= !nearly_full_n;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

// ==== verilog/header_parser.sv ====
module header_parser (
	input logic clk,
	input logic reset,
	input logic fifo_valid,
	input stream_pkg::flit_t fifo_flit,
	output logic fifo_pop,
	input logic slot_free,
	input ids_pkg::ip_addr_t compare_ip,
	output logic wr_en,
	output ids_pkg::buf_wr_t wr,
	output ids_pkg::count_t pkt_count
);

	ids_pkg::parse_state_t state;
	ids_pkg::parse_state_t state_n;
	logic [2:0] hdr_cnt; // body words seen so far
	logic [2:0] hdr_cnt_n;
	logic match;
	logic match_n;
	logic is_ctrl;
	logic pkt_done;

	assign is_ctrl = (fifo_flit.ctrl != '0);

	always_comb begin
		state_n = state;
		hdr_cnt_n = hdr_cnt;
		match_n = match;
		fifo_pop = 1'b0;
		wr_en = 1'b0;
		pkt_done = 1'b0;
		wr.flit = fifo_flit;
		wr.first = 1'b0;
		wr.last = 1'b0;
		wr.drop = match;

		case (state)
			ids_pkg::START: begin
				if (fifo_valid) begin
					if (!is_ctrl) begin
						fifo_pop = 1'b1; // stray word between packets
					end else if (slot_free) begin
						// read stop, otherwise wait for the next slot
						fifo_pop = 1'b1;
						wr_en = 1'b1;
						wr.first = 1'b1;
						hdr_cnt_n = '0;
						match_n = 1'b0;
						state_n = ids_pkg::HEADER;
					end
				end
			end
			ids_pkg::HEADER, ids_pkg::PAYLOAD: begin
				if (fifo_valid) begin
					fifo_pop = 1'b1;
					wr_en = 1'b1;
					if (is_ctrl) begin
						wr.last = 1'b1; // closes the packet
						pkt_done = 1'b1;
						state_n = ids_pkg::START;
					end else if (state == ids_pkg::HEADER) begin
						hdr_cnt_n = hdr_cnt + 1'b1;
						if (hdr_cnt_n == ids_pkg::SRC_WORD)
							match_n = (fifo_flit.data[31:0] == compare_ip);
						if (hdr_cnt_n == ids_pkg::HDR_WORDS)
							state_n = ids_pkg::PAYLOAD;
					end
				end
			end
			default: state_n = ids_pkg::START;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ids_pkg::START;
			hdr_cnt <= '0;
			match <= 1'b0;
			pkt_count <= '0;
		end else begin
			state <= state_n;
			hdr_cnt <= hdr_cnt_n;
			match <= match_n;
			if (pkt_done)
				pkt_count <= pkt_count + 1'b1;
		end
	end

	// a first word stays at the FIFO head while the next slot is busy
	property first_waits_for_slot;
		@(posedge clk) disable iff (reset)
		(state == ids_pkg::START && fifo_valid && is_ctrl && !slot_free)
			|=> (fifo_valid && $stable(fifo_flit));
	endproperty
	assert property (first_waits_for_slot);

endmodule

// ==== verilog/slot_buffer.sv ====
module slot_buffer (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input ids_pkg::buf_wr_t wr,
	output logic slot_free,
	output logic rd_valid,
	output ids_pkg::buf_rd_t rd,
	input logic rd_ready
);

	stream_pkg::flit_t mem [ids_pkg::NUM_SLOTS][ids_pkg::SLOT_DEPTH];
	ids_pkg::slot_addr_t last_addr [ids_pkg::NUM_SLOTS];

	logic [ids_pkg::NUM_SLOTS-1:0] used; // packet open or waiting
	logic [ids_pkg::NUM_SLOTS-1:0] committed; // last word written
	logic [ids_pkg::NUM_SLOTS-1:0] drop_mark;

	ids_pkg::slot_t wr_slot; // next slot to fill
	logic [$bits(ids_pkg::slot_addr_t):0] wr_cnt; // one bit wider to catch overruns
	ids_pkg::slot_addr_t wr_addr;

	ids_pkg::slot_t rd_slot;
	ids_pkg::slot_addr_t rd_addr;
	ids_pkg::slot_t out_slot; // slot of the word held in rd
	logic rd_at_last;
	logic load;
	logic take;

	assign slot_free = !used[wr_slot];
	assign wr_addr = wr.first ? '0 : wr_cnt[$bits(ids_pkg::slot_addr_t)-1:0];

	assign rd_at_last = (rd_addr == last_addr[rd_slot]);
	assign load = committed[rd_slot] && (!rd_valid || rd_ready);
	assign take = rd_valid && rd_ready;

	// storage and registered read data
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_slot][wr_addr] <= wr.flit;
		if (wr_en && wr.last) begin
			last_addr[wr_slot] <= wr_addr;
			drop_mark[wr_slot] <= wr.drop;
		end
		if (load) begin
			rd.flit <= mem[rd_slot][rd_addr];
			rd.last <= rd_at_last;
			rd.drop <= drop_mark[rd_slot];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			used <= '0;
			committed <= '0;
			wr_slot <= '0;
			wr_cnt <= '0;
			rd_slot <= '0;
			rd_addr <= '0;
			out_slot <= '0;
			rd_valid <= 1'b0;
		end else begin
			// slot released once its last word has moved on
			if (take && rd.last) begin
				used[out_slot] <= 1'b0;
				committed[out_slot] <= 1'b0;
			end

			if (wr_en) begin
				wr_cnt <= (wr.first ? '0 : wr_cnt) + 1'b1;
				if (wr.first)
					used[wr_slot] <= 1'b1;
				if (wr.last) begin
					committed[wr_slot] <= 1'b1;
					wr_slot <= wr_slot + 1'b1; // round robin
				end
			end

			if (load) begin
				rd_valid <= 1'b1;
				out_slot <= rd_slot;
				if (rd_at_last) begin
					rd_slot <= rd_slot + 1'b1; // same rotation as the writer
					rd_addr <= '0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end else if (take) begin
				rd_valid <= 1'b0;
			end
		end
	end

	// a packet never grows past the end of its slot
	property write_in_slot;
		@(posedge clk) disable iff (reset)
		wr_en |-> (wr.first || wr_cnt < ids_pkg::SLOT_DEPTH);
	endproperty
	assert property (write_in_slot);

endmodule

// ==== verilog/out_sched.sv ====
module out_sched (
	input logic clk,
	input logic reset,
	input logic rd_valid,
	input ids_pkg::buf_rd_t rd,
	output logic rd_ready,
	output logic out_valid,
	output stream_pkg::flit_t out_flit,
	input logic out_ready,
	output ids_pkg::count_t drop_count
);

	logic fwd;
	logic drop_end;

	// dropped words are swallowed without waiting on the output
	assign rd_ready = (rd_valid && rd.drop) || !out_valid || out_ready;
	assign fwd = rd_valid && rd_ready && !rd.drop;
	assign drop_end = rd_valid && rd.drop && rd.last;

	always_ff @(posedge clk) begin
		if (fwd)
			out_flit <= rd.flit;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			drop_count <= '0;
		end else begin
			if (fwd)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0; // word taken, nothing new
			if (drop_end)
				drop_count <= drop_count + 1'b1; // one per dropped packet
		end
	end

	// held word must not change under back-pressure
	property out_hold;
		@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_flit));
	endproperty
	assert property (out_hold);

endmodule

// ==== verilog/ids_top.sv ====
module ids_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input stream_pkg::flit_t in_flit,
	output logic in_ready,
	output logic out_valid,
	output stream_pkg::flit_t out_flit,
	input logic out_ready,
	input ids_pkg::ip_addr_t compare_ip,
	output ids_pkg::count_t pkt_count,
	output ids_pkg::count_t drop_count
);

	logic fifo_valid;
	stream_pkg::flit_t fifo_flit;
	logic fifo_pop;
	logic slot_free;
	logic wr_en;
	ids_pkg::buf_wr_t wr;
	logic rd_valid;
	ids_pkg::buf_rd_t rd;
	logic rd_ready;

	in_fifo i_in_fifo (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_flit    (in_flit),
		.in_ready   (in_ready),
		.fifo_valid (fifo_valid),
		.fifo_flit  (fifo_flit),
		.fifo_pop   (fifo_pop)
	);

	header_parser i_header_parser (
		.clk        (clk),
		.reset      (reset),
		.fifo_valid (fifo_valid),
		.fifo_flit  (fifo_flit),
		.fifo_pop   (fifo_pop),
		.slot_free  (slot_free),
		.compare_ip (compare_ip),
		.wr_en      (wr_en),
		.wr         (wr),
		.pkt_count  (pkt_count)
	);

	slot_buffer i_slot_buffer (
		.clk       (clk),
		.reset     (reset),
		.wr_en     (wr_en),
		.wr        (wr),
		.slot_free (slot_free),
		.rd_valid  (rd_valid),
		.rd        (rd),
		.rd_ready  (rd_ready)
	);

	out_sched i_out_sched (
		.clk        (clk),
		.reset      (reset),
		.rd_valid   (rd_valid),
		.rd         (rd),
		.rd_ready   (rd_ready),
		.out_valid  (out_valid),
		.out_flit   (out_flit),
		.out_ready  (out_ready),
		.drop_count (drop_count)
	);

endmodule

// ==== tb/tb_ids_tasks.svh ====
`ifndef TB_IDS_TASKS_SVH
`define TB_IDS_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic stream_pkg::word_t lfsr_word();
	stream_pkg::word_t w;
	int i;
	w = '0;
	for (i = 0; i < 64; i++)
		w = {w[62:0], lfsr_bit()};
	return w;
endfunction

// legal packet, control on first and last word, source in body word 4
task automatic build_packet(input int len, input ids_pkg::ip_addr_t src);
	stream_pkg::flit_t f;
	int i;
	pkt_q.delete();
	for (i = 0; i < len; i++) begin
		f.data = lfsr_word();
		f.ctrl = (i == 0) ? 8'h01 : ((i == len - 1) ? 8'h02 : 8'h00);
		if (i == ids_pkg::SRC_WORD)
			f.data[31:0] = src;
		pkt_q.push_back(f);
	end
endtask

task automatic step_cycle();
	@(negedge clk);
	if (rand_ready)
		out_ready = lfsr_bit();
endtask

task automatic send_packet(input logic gapped);
	int i;
	i = 0;
	while (i < pkt_q.size()) begin
		step_cycle();
		in_flit = pkt_q[i];
		in_valid = gapped ? lfsr_bit() : 1'b1;
		if (in_valid && in_ready)
			i++; // moves on the coming rising edge
	end
endtask

task automatic run_packet(input int len, input ids_pkg::ip_addr_t src, input logic gapped);
	build_packet(len, src);
	exp_pkt++;
	if (src == compare_ip)
		exp_drop++;
	else
		foreach (pkt_q[k]) exp_q.push_back(pkt_q[k]);
	send_packet(gapped);
endtask

task automatic check_count(input string name, input ids_pkg::count_t expv,
		input ids_pkg::count_t act);
	assert (act == expv) else begin
		errors++;
		$display("Fail %s expected %h actual %h", name, expv, act);
	end
endtask

task automatic wait_drain();
	int n;
	n = 0;
	step_cycle();
	in_valid = 1'b0;
	while ((rx_idx != exp_q.size() || pkt_count != exp_pkt || drop_count != exp_drop)
			&& n < DRAIN_CYCLES) begin
		step_cycle();
		n++;
	end
	assert (n < DRAIN_CYCLES) else begin
		errors++;
		$display("packets did not drain within %0d cycles", DRAIN_CYCLES);
	end
	check_count("pkt_count", exp_pkt, pkt_count);
	check_count("drop_count", exp_drop, drop_count);
endtask

task automatic test_idle();
	int n;
	for (n = 0; n < 20; n++) begin
		step_cycle();
		assert (!out_valid) else begin
			errors++;
			$display("Fail out_valid expected %h actual %h", 1'b0, out_valid);
		end
		assert (in_ready) else begin
			errors++;
			$display("Fail in_ready expected %h actual %h", 1'b1, in_ready);
		end
	end
	wait_drain();
endtask

task automatic test_single_keep();
	run_packet(10, 32'hc0a8_0001, 1'b0);
	wait_drain();
endtask

task automatic test_single_drop();
	run_packet(10, compare_ip, 1'b0);
	wait_drain();
endtask

task automatic test_back_to_back();
	int lens[10];
	int i;
	lens = '{7, 32, 12, 9, 20, 15, 8, 31, 10, 16};
	for (i = 0; i < 10; i++)
		run_packet(lens[i], (i % 3 == 1) ? compare_ip : 32'hc0a8_0100 + i, 1'b0);
	wait_drain();
endtask

task automatic test_backpressure();
	int i;
	rand_ready = 1'b1;
	for (i = 0; i < 12; i++)
		run_packet(7 + (i * 9) % 26, (i % 4 == 2) ? compare_ip : 32'hc0a8_0200 + i, 1'b1);
	wait_drain();
	rand_ready = 1'b0;
	out_ready = 1'b1;
endtask

// each packet judged against the address present while it passes the parser
task automatic test_ip_change();
	compare_ip = 32'h0a00_0005;
	run_packet(12, 32'h0a00_0005, 1'b0);
	compare_ip = 32'h0a00_0006; // last word of the previous packet still in flight
	run_packet(12, 32'h0a00_0005, 1'b0);
	run_packet(12, 32'h0a00_0006, 1'b0);
	compare_ip = 32'h0a00_0007;
	run_packet(12, 32'h0a00_0006, 1'b0);
	wait_drain();
endtask

`endif

// ==== tb/tb_ids.sv ====
module tb_ids;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int DRAIN_CYCLES = 2000; // bound on one drain
	// words over all tests, idle stretch of the first test included
	localparam int TEST_WORDS = 458;

	logic clk;
	logic reset;
	logic in_valid;
	stream_pkg::flit_t in_flit;
	logic in_ready;
	logic out_valid;
	stream_pkg::flit_t out_flit;
	logic out_ready;
	ids_pkg::ip_addr_t compare_ip;
	ids_pkg::count_t pkt_count;
	ids_pkg::count_t drop_count;

	stream_pkg::flit_t exp_q[$]; // every word expected at the output, in order
	stream_pkg::flit_t pkt_q[$]; // packet under construction
	ids_pkg::count_t exp_pkt;
	ids_pkg::count_t exp_drop;
	logic [31:0] lfsr_state;
	logic rand_ready; // out_ready follows the LFSR
	int errors = 0;
	int mon_errors = 0;
	int rx_idx = 0; // next entry of exp_q the output must match

	ids_top i_ids_top (.*);

	`include "tb_ids_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// output checker, one compare per transfer
	always @(posedge clk) begin
		if (!reset && out_valid && out_ready) begin
			assert (rx_idx < exp_q.size()) else begin
				mon_errors++;
				$display("output word %h appeared with no packet expected", out_flit);
			end
			if (rx_idx < exp_q.size()) begin
				assert (out_flit == exp_q[rx_idx]) else begin
					mon_errors++;
					$display("Fail out_flit expected %h actual %h", exp_q[rx_idx], out_flit);
				end
				rx_idx++;
			end
		end
	end

	initial begin
		repeat (TEST_WORDS * 40) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_flit = '0;
		out_ready = 1'b1;
		compare_ip = 32'h0a00_0001;
		exp_pkt = '0;
		exp_drop = '0;
		lfsr_state = 32'hfe4d;
		rand_ready = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		test_idle();
		test_single_keep();
		test_single_drop();
		test_back_to_back();
		test_backpressure();
		test_ip_change();

		$display("words checked %0d, errors %0d", rx_idx, errors + mon_errors);
		if (errors + mon_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+tb
verilog/stream_pkg.sv
verilog/ids_pkg.sv
verilog/in_fifo.sv
verilog/header_parser.sv
verilog/slot_buffer.sv
verilog/out_sched.sv
verilog/ids_top.sv
tb/tb_ids.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_ids
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
